// File: sim/icache_vectors.txt
// tag(hex) index(hex) offset(hex) uncached miss
// miss = 1 when the fetch must go to the bus
00010 05 08 0 1
00010 05 0c 0 0
00010 05 1c 0 0
00010 05 00 0 0
00010 05 10 0 0
00020 06 1c 0 1
00020 06 1c 0 0
// uncached reads leave the set empty
00030 07 14 1 1
00030 07 14 0 1
00030 07 18 0 0
00030 07 04 1 1
00030 07 04 0 0
00031 07 16 1 1
// three tags in set 40, round robin counts every refill
00100 40 00 0 1
00200 40 04 0 1
00100 40 08 0 0
00200 40 0c 0 0
00300 40 10 0 1
00100 40 14 0 0
00200 40 18 0 1
00300 40 1c 0 0
00100 40 00 0 1
00200 40 04 0 0
00300 40 08 0 1
00100 40 0c 0 0
00010 05 1c 0 0
00011 05 00 0 1
00010 05 04 0 0

// File: icache_top.f
+incdir+verilog
verilog/icache_pkg.sv
verilog/icache_way.sv
verilog/icache_ctrl.sv
verilog/icache_fetch_merge.sv
verilog/icache_top.sv
sim/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --timescale 1ns/1ps
TOP       := icache_tb
FILELIST  := icache_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/icache_tb.sv
/* icache testbench
   vector-driven fetches against a bus memory model with random beat gaps */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_tb;

    localparam int VEC_MAX = 64;
    localparam int VF      = 5;    // tag, index, offset, uncached, miss

    logic                           clk = 1'b0;
    logic                           reset;
    logic                           valid;
    logic [`ICACHE_INDEX_W-1:0]     index;
    logic [`ICACHE_TAG_W-1:0]       tag;
    logic [`ICACHE_OFFSET_W-1:0]    offset;
    logic                           is_uncache;
    logic                           rd_rdy;
    logic                           ret_valid;
    logic                           ret_last;
    logic [`ICACHE_WORD_W-1:0]      ret_data;
    wire                            addr_ok;
    wire                            inst_rdata1_ok;
    wire                            inst_rdata2_ok;
    wire [`ICACHE_WORD_W-1:0]       inst_rdata1;
    wire [`ICACHE_WORD_W-1:0]       inst_rdata2;
    wire                            rd_req;
    wire [`ICACHE_RD_TYPE_W-1:0]    rd_type;
    wire [`ICACHE_ADDR_W-1:0]       rd_addr;

    logic [31:0]    vec_mem [VEC_MAX*VF];
    int             nvec;
    int             cur_vec;
    int             cycle_cnt = 0;
    int             cycle_limit = 100;
    int             retired = 0;
    int             pend_q[$];         // accepted and not yet returned
    int             accept_cycle [VEC_MAX];
    logic           missed [VEC_MAX];
    integer         seed = 46890;

    icache_top dut (.*);

    always #20 clk = ~clk;

    // memory content is the inverted word address
    function automatic logic [`ICACHE_WORD_W-1:0] mem_word(input logic [`ICACHE_ADDR_W-1:0] a);
        return ~{a[`ICACHE_ADDR_W-1:2], 2'b00};
    endfunction

    function automatic icache_pkg::fetch_addr_u request_addr(input int v);
        icache_pkg::fetch_addr_u a;
        a.raw = {vec_mem[v*VF][`ICACHE_TAG_W-1:0], vec_mem[v*VF+1][`ICACHE_INDEX_W-1:0],
                 vec_mem[v*VF+2][`ICACHE_OFFSET_W-1:0]};
        return a;
    endfunction

    function automatic logic uncached_at(input int v);
        return vec_mem[v*VF+3][0];
    endfunction

    function automatic logic miss_expected(input int v);
        return vec_mem[v*VF+4][0];
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic verify_read(input icache_pkg::fetch_addr_u got_addr, exp_addr,
                               input logic [`ICACHE_RD_TYPE_W-1:0] got_type, exp_type);
        if (got_type !== exp_type) begin
            $display("ERR rd_type got %h expected %h", got_type, exp_type);
            abort_run();
        end
        if (got_addr.raw !== exp_addr.raw) begin
            $display("ERR rd_addr got %h expected %h", got_addr.raw, exp_addr.raw);
            abort_run();
        end
    endtask

    task automatic compare_word(input string name, input logic [`ICACHE_WORD_W-1:0] got, exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic match_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    always @(posedge clk) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout, run hung waiting for a result after %0d cycles", cycle_cnt);
            abort_run();
        end
    end

    // bus slave answers rd_rdy after 0..3 cycles and spaces beats by 0..3 idle cycles
    initial begin : bus_model
        logic [`ICACHE_ADDR_W-1:0] base;
        int nbeats;
        int gap;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        forever begin
            @(posedge clk);
            if (!reset && rd_req) begin
                base = rd_addr;
                nbeats = (rd_type == `ICACHE_RD_LINE) ? `ICACHE_LINE_WORDS : 1;
                gap = $random(seed) & 3;
                repeat (gap) @(posedge clk);
                @(negedge clk);
                rd_rdy = 1'b1;
                @(negedge clk);
                rd_rdy = 1'b0;
                for (int k = 0; k < nbeats; k++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk);
                    ret_valid = 1'b1;
                    ret_last = (k == nbeats - 1);
                    ret_data = mem_word(base + 32'(4 * k));
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin : monitor
        int v;
        icache_pkg::fetch_addr_u a;
        icache_pkg::fetch_addr_u exp_addr;
        logic unc;
        if (!reset) begin
            if (rd_req && rd_rdy) begin
                if (pend_q.size() == 0) begin
                    $display("bus read issued with no fetch pending");
                    abort_run();
                end else begin
                    v = pend_q[0];
                    a = request_addr(v);
                    missed[v] = 1'b1;
                    exp_addr = a;
                    if (!uncached_at(v)) begin
                        exp_addr.f.word = '0;       // burst from line base
                        exp_addr.f.byte_sel = '0;
                    end
                    verify_read(rd_addr, exp_addr, rd_type,
                                uncached_at(v) ? `ICACHE_RD_WORD : `ICACHE_RD_LINE);
                end
            end
            if (inst_rdata1_ok || inst_rdata2_ok) begin
                if (pend_q.size() == 0) begin
                    $display("result returned with no fetch pending");
                    abort_run();
                end else begin
                    v = pend_q.pop_front();
                    a = request_addr(v);
                    unc = uncached_at(v);
                    match_flag("inst_rdata1_ok", inst_rdata1_ok, 1'b1);
                    match_flag("inst_rdata2_ok", inst_rdata2_ok, !unc);
                    match_flag("rd_req", missed[v], miss_expected(v));
                    compare_word("inst_rdata1", inst_rdata1, mem_word(a.raw));
                    if (!unc) begin
                        exp_addr = a;
                        exp_addr.f.word = a.f.word + 1'b1;   // wraps inside the line
                        compare_word("inst_rdata2", inst_rdata2, mem_word(exp_addr.raw));
                    end
                    if (!miss_expected(v) && cycle_cnt != accept_cycle[v] + 1) begin
                        $display("hit for vector %0d came %0d cycles after acceptance",
                                 v, cycle_cnt - accept_cycle[v]);
                        abort_run();
                    end
                    retired <= retired + 1;
                end
            end
            if (valid && addr_ok) begin
                pend_q.push_back(cur_vec);
                accept_cycle[cur_vec] = cycle_cnt;
                missed[cur_vec] = 1'b0;
            end
        end
    end

    initial begin : main_seq
        icache_pkg::fetch_addr_u a;
        reset = 1'b1;
        valid = 1'b0;
        index = '0;
        tag = '0;
        offset = '0;
        is_uncache = 1'b0;
        cur_vec = 0;
        for (int i = 0; i < VEC_MAX * VF; i++) begin
            vec_mem[i] = '1;    // wider than any tag so it marks the end
        end
        $readmemh("sim/icache_vectors.txt", vec_mem);
        nvec = 0;
        while (nvec < VEC_MAX && vec_mem[nvec*VF] != '1) begin
            nvec++;
        end
        cycle_limit = nvec * 40 + 100;

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        match_flag("addr_ok", addr_ok, 1'b1);
        match_flag("rd_req", rd_req, 1'b0);
        match_flag("inst_rdata1_ok", inst_rdata1_ok, 1'b0);
        match_flag("inst_rdata2_ok", inst_rdata2_ok, 1'b0);

        for (int i = 0; i < nvec; i++) begin
            @(negedge clk);
            a = request_addr(i);
            cur_vec = i;
            valid = 1'b1;
            tag = a.f.tag;
            index = a.f.index;
            offset = a.raw[`ICACHE_OFFSET_W-1:0];
            is_uncache = uncached_at(i);
            do begin
                @(posedge clk);
            end while (!addr_ok);
        end
        @(negedge clk);
        valid = 1'b0;
        wait (retired == nvec);
        repeat (2) @(posedge clk);
        match_flag("rd_req", rd_req, 1'b0);

        if (nvec > 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("no vectors were read from the vector file");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_top.sv
/* two-way instruction cache top level
   controller, way array and result merge */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_top (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              valid,
    input  wire [`ICACHE_INDEX_W-1:0]        index,
    input  wire [`ICACHE_TAG_W-1:0]          tag,
    input  wire [`ICACHE_OFFSET_W-1:0]       offset,
    input  wire                              is_uncache,
    output wire                              addr_ok,
    output wire                              inst_rdata1_ok,
    output wire                              inst_rdata2_ok,
    output wire [`ICACHE_WORD_W-1:0]         inst_rdata1,
    output wire [`ICACHE_WORD_W-1:0]         inst_rdata2,
    input  wire                              rd_rdy,
    input  wire                              ret_valid,
    input  wire                              ret_last,
    input  wire [`ICACHE_WORD_W-1:0]         ret_data,
    output wire                              rd_req,
    output wire [`ICACHE_RD_TYPE_W-1:0]      rd_type,
    output wire [`ICACHE_ADDR_W-1:0]         rd_addr
);

    wire [`ICACHE_INDEX_W-1:0]                    rd_index;
    wire icache_pkg::way_wr_t                     way_wr;
    wire icache_pkg::fetch_req_t                  req;
    wire icache_pkg::way_resp_t [`ICACHE_WAYS-1:0] resp;
    wire                                          refill_done;
    wire                                          in_lookup;
    wire                                          lookup_hit;
    wire [`ICACHE_WAYS-1:0]                       victim_sel;

    icache_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .index       (index),
        .tag         (tag),
        .offset      (offset),
        .is_uncache  (is_uncache),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .lookup_hit  (lookup_hit),
        .victim_sel  (victim_sel),
        .addr_ok     (addr_ok),
        .rd_req      (rd_req),
        .rd_type     (rd_type),
        .rd_addr     (rd_addr),
        .rd_index    (rd_index),
        .way_wr      (way_wr),
        .req         (req),
        .refill_done (refill_done),
        .in_lookup   (in_lookup)
    );

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way #(
            .WAY_ID (w)
        ) u_way (
            .clk      (clk),
            .reset    (reset),
            .rd_index (rd_index),
            .req      (req),
            .way_wr   (way_wr),
            .resp     (resp[w])
        );
    end

    icache_fetch_merge u_merge (
        .clk            (clk),
        .reset          (reset),
        .resp           (resp),
        .req            (req),
        .ret_valid      (ret_valid),
        .ret_data       (ret_data),
        .refill_done    (refill_done),
        .in_lookup      (in_lookup),
        .lookup_hit     (lookup_hit),
        .victim_sel     (victim_sel),
        .inst_rdata1    (inst_rdata1),
        .inst_rdata2    (inst_rdata2),
        .inst_rdata1_ok (inst_rdata1_ok),
        .inst_rdata2_ok (inst_rdata2_ok)
    );

endmodule

`default_nettype wire

// File: verilog/icache_fetch_merge.sv
/* icache result merge
   hit select across ways, uncached data return and victim choice */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_fetch_merge (
    input  wire                                       clk,
    input  wire                                       reset,
    input  wire icache_pkg::way_resp_t [`ICACHE_WAYS-1:0] resp,
    input  wire icache_pkg::fetch_req_t               req,
    input  wire                                       ret_valid,
    input  wire [`ICACHE_WORD_W-1:0]                  ret_data,
    input  wire                                       refill_done,
    input  wire                                       in_lookup,
    output logic                                      lookup_hit,
    output logic [`ICACHE_WAYS-1:0]                   victim_sel,
    output logic [`ICACHE_WORD_W-1:0]                 inst_rdata1,
    output logic [`ICACHE_WORD_W-1:0]                 inst_rdata2,
    output logic                                      inst_rdata1_ok,
    output logic                                      inst_rdata2_ok
);

    localparam int RR_W = (`ICACHE_WAYS > 1) ? $clog2(`ICACHE_WAYS) : 1;

    logic [RR_W-1:0]            rr_q;
    logic                       any_hit;
    logic [`ICACHE_WORD_W-1:0]  hit_word1;
    logic [`ICACHE_WORD_W-1:0]  hit_word2;

    always_comb begin
        any_hit   = 1'b0;
        hit_word1 = '0;
        hit_word2 = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (resp[w].hit) begin
                any_hit   = 1'b1;
                hit_word1 = hit_word1 | resp[w].word1;
                hit_word2 = hit_word2 | resp[w].word2;
            end
        end
    end

    assign lookup_hit = any_hit && !req.uncached;

    assign inst_rdata1    = req.uncached ? ret_data : hit_word1;
    assign inst_rdata2    = hit_word2;
    assign inst_rdata1_ok = (in_lookup && lookup_hit) || (req.uncached && ret_valid);
    assign inst_rdata2_ok = in_lookup && lookup_hit;

    // lowest invalid way wins, else round robin
    always_comb begin
        victim_sel       = '0;
        victim_sel[rr_q] = 1'b1;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!resp[w].valid) begin
                victim_sel    = '0;
                victim_sel[w] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_q <= '0;
        end else if (refill_done) begin
            if (rr_q == RR_W'(`ICACHE_WAYS - 1)) begin
                rr_q <= '0;
            end else begin
                rr_q <= rr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/icache_ctrl.sv
/* icache controller
   request register, lookup/refill FSM, beat counter and bus reads */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_ctrl (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              valid,
    input  wire [`ICACHE_INDEX_W-1:0]        index,
    input  wire [`ICACHE_TAG_W-1:0]          tag,
    input  wire [`ICACHE_OFFSET_W-1:0]       offset,
    input  wire                              is_uncache,
    input  wire                              rd_rdy,
    input  wire                              ret_valid,
    input  wire                              ret_last,
    input  wire [`ICACHE_WORD_W-1:0]         ret_data,
    input  wire                              lookup_hit,
    input  wire [`ICACHE_WAYS-1:0]           victim_sel,
    output logic                             addr_ok,
    output logic                             rd_req,
    output logic [`ICACHE_RD_TYPE_W-1:0]     rd_type,
    output logic [`ICACHE_ADDR_W-1:0]        rd_addr,
    output logic [`ICACHE_INDEX_W-1:0]       rd_index,
    output icache_pkg::way_wr_t              way_wr,
    output icache_pkg::fetch_req_t           req,
    output logic                             refill_done,
    output logic                             in_lookup
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_bus_req,
        st_refill,
        st_replay
    } state_e;

    state_e                     state_q;
    state_e                     state_d;
    icache_pkg::fetch_req_t     req_q;
    logic [`ICACHE_WAYS-1:0]    victim_q;
    logic [`ICACHE_WSEL_W-1:0]  beat_cnt;
    logic                       accept;
    logic                       line_beat;

    assign accept      = valid && addr_ok;
    assign line_beat   = (state_q == st_refill) && ret_valid && !req_q.uncached;
    assign refill_done = line_beat && ret_last;
    assign in_lookup   = (state_q == st_lookup);
    assign req         = req_q;

    // new request index when accepting, otherwise re-read the pending set
    assign rd_index = accept ? index : req_q.addr.f.index;

    always_comb begin
        case (state_q)
            st_idle:   addr_ok = 1'b1;
            st_lookup: addr_ok = lookup_hit ? valid : 1'b0;  // hit frees the slot
            default:   addr_ok = 1'b0;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (!lookup_hit) begin
                    state_d = st_bus_req;  // miss or uncached
                end else if (!accept) begin
                    state_d = st_idle;
                end
            end
            st_bus_req: begin
                if (rd_rdy) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                if (ret_valid && req_q.uncached) begin
                    state_d = st_idle;
                end else if (refill_done) begin
                    state_d = st_replay;
                end
            end
            st_replay: state_d = st_lookup;
            default:   state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.addr.raw <= {tag, index, offset};
            req_q.uncached <= is_uncache;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            victim_q <= '0;
            beat_cnt <= '0;
        end else begin
            if (in_lookup && state_d == st_bus_req) begin
                victim_q <= victim_sel;
            end
            if (state_q != st_refill) begin
                beat_cnt <= '0;
            end else if (ret_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        way_wr.way_sel   = line_beat ? victim_q : '0;
        way_wr.word      = beat_cnt;
        way_wr.data      = ret_data;
        way_wr.line_done = refill_done;
    end

    // burst reads start at the line base
    assign rd_req  = (state_q == st_bus_req);
    assign rd_type = req_q.uncached ? `ICACHE_RD_WORD : `ICACHE_RD_LINE;
    assign rd_addr = req_q.uncached ? req_q.addr.raw :
                     {req_q.addr.f.tag, req_q.addr.f.index, {`ICACHE_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

// File: verilog/icache_way.sv
/* one icache way
   tag, valid and line storage with tag compare and two-word read */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_way #(
    parameter int WAY_ID = 0
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire [`ICACHE_INDEX_W-1:0]        rd_index,
    input  wire icache_pkg::fetch_req_t      req,
    input  wire icache_pkg::way_wr_t         way_wr,
    output icache_pkg::way_resp_t            resp
);

    logic [`ICACHE_SETS-1:0]                                valid_q;
    logic [`ICACHE_TAG_W-1:0]                               tag_ram [`ICACHE_SETS];
    logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0]      data_ram [`ICACHE_SETS];

    logic                                                   valid_r;
    logic [`ICACHE_TAG_W-1:0]                               tag_q;
    logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_WORD_W-1:0]      line_q;

    logic                                                   wr_en;
    logic [`ICACHE_WSEL_W-1:0]                              next_word;

    assign wr_en = way_wr.way_sel[WAY_ID];

    // refill writes go to the set of the pending request
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_ram[req.addr.f.index][way_wr.word] <= way_wr.data;
            if (way_wr.line_done) begin
                tag_ram[req.addr.f.index] <= req.addr.f.tag;
            end
        end
        tag_q  <= tag_ram[rd_index];     // synchronous read
        line_q <= data_ram[rd_index];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            valid_r <= 1'b0;
        end else begin
            if (wr_en && way_wr.line_done) begin
                valid_q[req.addr.f.index] <= 1'b1;
            end
            valid_r <= valid_q[rd_index];
        end
    end

    assign next_word = req.addr.f.word + 1'b1;  // wraps to word 0

    always_comb begin
        resp.valid = valid_r;
        resp.hit   = valid_r && (tag_q == req.addr.f.tag);
        resp.word1 = line_q[req.addr.f.word];
        resp.word2 = line_q[next_word];
    end

endmodule

`default_nettype wire

// File: verilog/icache_pkg.sv
/* icache shared types
   address views, refill write command, way result and request register */
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic [`ICACHE_WSEL_W-1:0]  word;
        logic [`ICACHE_BYTE_W-1:0]  byte_sel;
    } addr_fields_t;

    // raw bus address or decoded fields over the same bits
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        addr_fields_t              f;
    } fetch_addr_u;

    typedef struct packed {
        logic [`ICACHE_WAYS-1:0]   way_sel;    // one-hot where all zero means no write
        logic [`ICACHE_WSEL_W-1:0] word;
        logic [`ICACHE_WORD_W-1:0] data;
        logic                      line_done;  // last beat sets tag and valid
    } way_wr_t;

    typedef struct packed {
        logic                      hit;
        logic                      valid;
        logic [`ICACHE_WORD_W-1:0] word1;
        logic [`ICACHE_WORD_W-1:0] word2;
    } way_resp_t;

    typedef struct packed {
        fetch_addr_u addr;
        logic        uncached;
    } fetch_req_t;

endpackage

`default_nettype wire

// File: verilog/icache_cfg.svh
/* icache geometry and bus encodings
   two ways, 256 sets, eight 32-bit words per line */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

`define ICACHE_WAYS        2
`define ICACHE_INDEX_W     8
`define ICACHE_TAG_W       19
`define ICACHE_OFFSET_W    5
`define ICACHE_LINE_WORDS  8
`define ICACHE_WORD_W      32

// word number within a line from the upper offset bits
`define ICACHE_WSEL_W      (`ICACHE_OFFSET_W - 2)
`define ICACHE_BYTE_W      (`ICACHE_OFFSET_W - `ICACHE_WSEL_W)
`define ICACHE_SETS        (1 << `ICACHE_INDEX_W)
`define ICACHE_ADDR_W      (`ICACHE_TAG_W + `ICACHE_INDEX_W + `ICACHE_OFFSET_W)

// bus read types
`define ICACHE_RD_TYPE_W   3
`define ICACHE_RD_WORD     3'd2    // single uncached word
`define ICACHE_RD_LINE     3'd7    // eight-beat line burst

`endif
